// ==== dcache_pkg.sv ====
// data cache shared definitions
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////

    // 16 sets
    localparam int INDEX_WIDTH  = 4;
    // 4 words per line
    localparam int OFFSET_WIDTH = 2;
    localparam int WAYS         = 2;
    // bits above index, offset and byte
    localparam int TAG_WIDTH    = 24;
    localparam int LINE_BITS    = 128;
    localparam int SETS         = 1 << INDEX_WIDTH;

    ////////////////////////////////////////////////////////////
    // request address, raw or split into lookup fields
    ////////////////////////////////////////////////////////////

    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [TAG_WIDTH-1:0]    tag;
            logic [INDEX_WIDTH-1:0]  index;
            logic [OFFSET_WIDTH-1:0] offset;
            logic [1:0]              byte_sel;
        } fields;
    } dcache_addr_u;

    // resolve stage FSM
    typedef enum logic [2:0] {
        idle,
        lookup,
        miss_req,
        miss_wait,
        write_req,
        write_wait
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== dcache_tag_array.sv ====
// data cache tag and lru array
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0] rd_index,
    input  logic [dcache_pkg::TAG_WIDTH-1:0]   cmp_tag,
    input  logic                             tag_we,
    input  logic                             wr_way,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0] wr_index,
    input  logic [dcache_pkg::TAG_WIDTH-1:0]   wr_tag,
    input  logic                             lru_touch,
    input  logic                             lru_way,
    output logic [dcache_pkg::WAYS-1:0]        hit,
    output logic                             victim_way
);
    import dcache_pkg::*;

    logic [TAG_WIDTH-1:0] tag_mem [WAYS][SETS];
    logic [SETS-1:0]      valid_q [WAYS];
    // way to replace next, per set
    logic [SETS-1:0]      lru_q;

    logic [TAG_WIDTH-1:0] rd_tag_q [WAYS];
    logic [WAYS-1:0]      rd_valid_q;
    logic                 rd_lru_q;

    ////////////////////////////////////////////////////////////
    // storage and registered set read
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[wr_way][wr_index] <= wr_tag;
        end
        for (int w = 0; w < WAYS; w++) begin
            rd_tag_q[w] <= tag_mem[w][rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WAYS; w++) begin
                valid_q[w] <= '0;
            end
            lru_q      <= '0;
            rd_valid_q <= '0;
            rd_lru_q   <= 1'b0;
        end else begin
            if (tag_we) begin
                valid_q[wr_way][wr_index] <= 1'b1;
            end
            if (lru_touch) begin
                lru_q[wr_index] <= ~lru_way;
            end
            for (int w = 0; w < WAYS; w++) begin
                rd_valid_q[w] <= valid_q[w][rd_index];
            end
            // a hit in the resolve stage can touch the set being read
            if (lru_touch && (wr_index == rd_index)) begin
                rd_lru_q <= ~lru_way;
            end else begin
                rd_lru_q <= lru_q[rd_index];
            end
        end
    end

    // compare against the buffered tag
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit[w] = rd_valid_q[w] && (rd_tag_q[w] == cmp_tag);
        end
    end

    // fill an empty way first, else the lru way
    assign victim_way = !rd_valid_q[0] ? 1'b0 :
                        !rd_valid_q[1] ? 1'b1 : rd_lru_q;

endmodule

`default_nettype wire

// ==== dcache_data_array.sv ====
// data cache line storage
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array (
    input  logic                              clk,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0]  rd_index,
    input  logic                              word_we,
    input  logic                              line_we,
    input  logic                              wr_way,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0]  wr_index,
    input  logic [dcache_pkg::OFFSET_WIDTH-1:0] wr_offset,
    input  logic [3:0]                        wr_strb,
    input  logic [31:0]                       wr_word,
    input  logic [dcache_pkg::LINE_BITS-1:0]    wr_line,
    input  logic                              sel_way,
    input  logic                              sel_refill,
    input  logic [dcache_pkg::OFFSET_WIDTH-1:0] sel_offset,
    output logic [31:0]                       rd_word
);
    import dcache_pkg::*;

    logic [LINE_BITS-1:0] line_mem [WAYS][SETS];
    logic [LINE_BITS-1:0] rd_line_q [WAYS];

    // last refilled line, for the reply after the fill
    logic [LINE_BITS-1:0] refill_q;
    logic [LINE_BITS-1:0] sel_line;

    ////////////////////////////////////////////////////////////
    // writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (line_we) begin
            line_mem[wr_way][wr_index] <= wr_line;
        end else if (word_we) begin
            // merge only the strobed bytes
            for (int b = 0; b < 4; b++) begin
                if (wr_strb[b]) begin
                    line_mem[wr_way][wr_index][32 * wr_offset + 8 * b +: 8] <=
                        wr_word[8 * b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            refill_q <= wr_line;
        end
    end

    ////////////////////////////////////////////////////////////
    // registered line read and word select
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            rd_line_q[w] <= line_mem[w][rd_index];
        end
    end

    always_comb begin
        if (sel_refill) begin
            sel_line = refill_q;
        end else begin
            sel_line = rd_line_q[sel_way];
        end
        rd_word = sel_line[32 * sel_offset +: 32];
    end

endmodule

`default_nettype wire

// ==== dcache_ctrl.sv ====
// data cache resolve stage controller
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req_valid,
    input  logic                        req_write,
    input  logic [31:0]                 req_addr,
    input  logic [31:0]                 req_wdata,
    input  logic [3:0]                  req_wstrb,
    input  logic [dcache_pkg::WAYS-1:0]   hit,
    input  logic                        victim_way,
    input  logic                        mem_addr_ok,
    input  logic                        mem_data_ok,
    output logic                        req_ready,
    output logic                        resp_valid,
    output dcache_pkg::dcache_addr_u      buf_addr,
    output logic [31:0]                 buf_wdata,
    output logic [3:0]                  buf_wstrb,
    output logic                        tag_we,
    output logic                        lru_touch,
    output logic                        word_we,
    output logic                        line_we,
    output logic                        arr_way,
    output logic                        sel_refill,
    output logic                        mem_req,
    output logic                        mem_write,
    output logic [31:0]                 mem_addr
);
    import dcache_pkg::*;

    ctrl_state_e  state;
    ctrl_state_e  state_next;
    logic         buf_write;
    logic         victim_q;
    // reply pending, one cycle after mem_data_ok
    logic         reply_q;
    logic         hit_any;
    logic         read_hit;
    logic         accept;
    dcache_addr_u line_addr;

    assign hit_any  = |hit;
    assign read_hit = (state == lookup) && !buf_write && hit_any;

    // a read hit frees the buffer in the same cycle
    assign req_ready  = (state == idle) || read_hit;
    assign accept     = req_valid && req_ready;
    assign resp_valid = read_hit || reply_q;
    assign sel_refill = reply_q;

    ////////////////////////////////////////////////////////////
    // request buffer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_addr.raw <= req_addr;
            buf_wdata    <= req_wdata;
            buf_wstrb    <= req_wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_write <= 1'b0;
        end else if (accept) begin
            buf_write <= req_write;
        end
    end

    // victim is only valid in the lookup cycle
    always_ff @(posedge clk) begin
        if (state == lookup) begin
            victim_q <= victim_way;
        end
    end

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= idle;
            reply_q <= 1'b0;
        end else begin
            state   <= state_next;
            reply_q <= mem_data_ok && ((state == miss_wait) || (state == write_wait));
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (accept) begin
                    state_next = lookup;
                end
            end
            lookup: begin
                if (buf_write) begin
                    state_next = mem_addr_ok ? write_wait : write_req;
                end else if (hit_any) begin
                    state_next = accept ? lookup : idle;
                end else begin
                    state_next = mem_addr_ok ? miss_wait : miss_req;
                end
            end
            miss_req: begin
                if (mem_addr_ok) begin
                    state_next = miss_wait;
                end
            end
            miss_wait: begin
                if (mem_data_ok) begin
                    state_next = idle;
                end
            end
            write_req: begin
                if (mem_addr_ok) begin
                    state_next = write_wait;
                end
            end
            write_wait: begin
                if (mem_data_ok) begin
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    // array writes and memory request
    always_comb begin
        mem_req   = 1'b0;
        tag_we    = 1'b0;
        line_we   = 1'b0;
        word_we   = 1'b0;
        lru_touch = 1'b0;
        arr_way   = hit[1];
        case (state)
            lookup: begin
                mem_req   = buf_write || !hit_any;
                word_we   = buf_write && hit_any;
                lru_touch = hit_any;
            end
            miss_req, write_req: begin
                mem_req = 1'b1;
            end
            miss_wait: begin
                arr_way   = victim_q;
                tag_we    = mem_data_ok;
                line_we   = mem_data_ok;
                lru_touch = mem_data_ok;
            end
            default: begin
                mem_req = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // memory address, line aligned for refills
    ////////////////////////////////////////////////////////////

    always_comb begin
        line_addr                 = buf_addr;
        line_addr.fields.offset   = '0;
        line_addr.fields.byte_sel = '0;
    end

    assign mem_write = buf_write;
    assign mem_addr  = buf_write ? buf_addr.raw : line_addr.raw;

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
// two way write-through data cache
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                           clk,
    input  logic                           reset,
    // pipeline side
    input  logic                           req_valid,
    input  logic                           req_write,
    input  logic [31:0]                    req_addr,
    input  logic [31:0]                    req_wdata,
    input  logic [3:0]                     req_wstrb,
    output logic                           req_ready,
    output logic                           resp_valid,
    output logic [31:0]                    resp_rdata,
    // memory side
    output logic                           mem_req,
    output logic                           mem_write,
    output logic [31:0]                    mem_addr,
    output logic [31:0]                    mem_wdata,
    output logic [3:0]                     mem_wstrb,
    input  logic                           mem_addr_ok,
    input  logic                           mem_data_ok,
    input  logic [dcache_pkg::LINE_BITS-1:0] mem_rdata
);
    import dcache_pkg::*;

    dcache_addr_u    req_addr_u;
    dcache_addr_u    buf_addr;
    logic [31:0]     buf_wdata;
    logic [3:0]      buf_wstrb;
    logic [WAYS-1:0] hit;
    logic            victim_way;
    logic            tag_we;
    logic            lru_touch;
    logic            word_we;
    logic            line_we;
    logic            arr_way;
    logic            sel_refill;

    assign req_addr_u.raw = req_addr;

    // write-through data straight from the buffer
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;

    ////////////////////////////////////////////////////////////
    // lookup stage arrays
    ////////////////////////////////////////////////////////////

    dcache_tag_array i_dcache_tag_array (
        .clk        (clk),
        .reset      (reset),
        .rd_index   (req_addr_u.fields.index),
        .cmp_tag    (buf_addr.fields.tag),
        .tag_we     (tag_we),
        .wr_way     (arr_way),
        .wr_index   (buf_addr.fields.index),
        .wr_tag     (buf_addr.fields.tag),
        .lru_touch  (lru_touch),
        .lru_way    (arr_way),
        .hit        (hit),
        .victim_way (victim_way)
    );

    dcache_data_array i_dcache_data_array (
        .clk        (clk),
        .rd_index   (req_addr_u.fields.index),
        .word_we    (word_we),
        .line_we    (line_we),
        .wr_way     (arr_way),
        .wr_index   (buf_addr.fields.index),
        .wr_offset  (buf_addr.fields.offset),
        .wr_strb    (buf_wstrb),
        .wr_word    (buf_wdata),
        .wr_line    (mem_rdata),
        .sel_way    (arr_way),
        .sel_refill (sel_refill),
        .sel_offset (buf_addr.fields.offset),
        .rd_word    (resp_rdata)
    );

    // resolve stage
    dcache_ctrl i_dcache_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wstrb   (req_wstrb),
        .hit         (hit),
        .victim_way  (victim_way),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .buf_addr    (buf_addr),
        .buf_wdata   (buf_wdata),
        .buf_wstrb   (buf_wstrb),
        .tag_we      (tag_we),
        .lru_touch   (lru_touch),
        .word_we     (word_we),
        .line_we     (line_we),
        .arr_way     (arr_way),
        .sel_refill  (sel_refill),
        .mem_req     (mem_req),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr)
    );

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
// memory responder for the cache testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  logic         clk,
    input  logic         reset,
    input  logic         mem_req,
    input  logic         mem_write,
    input  logic [31:0]  mem_addr,
    input  logic [31:0]  mem_wdata,
    input  logic [3:0]   mem_wstrb,
    output logic         mem_addr_ok,
    output logic         mem_data_ok,
    output logic [127:0] mem_rdata,
    output int           read_count,
    output int           write_count,
    output logic [31:0]  last_addr,
    output logic [3:0]   last_strb
);
    logic [7:0]  store [4096];
    logic [31:0] rng;
    // 0 idle, 1 address delay, 2 address taken, 3 data delay, 4 data sent
    logic [2:0]  phase;
    logic [2:0]  wait_cnt;
    logic [11:0] line_base;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // same pattern as the testbench shadow copy
    function automatic logic [7:0] fill_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
    endfunction

    initial begin
        rng         = 32'd8137;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        for (int i = 0; i < 4096; i++) begin
            store[i] = fill_byte(12'(i));
        end
    end

    always @(posedge clk) begin
        rng <= xorshift32(rng);
        if (reset) begin
            phase       <= 3'd0;
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            read_count  <= 0;
            write_count <= 0;
        end else begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            case (phase)
                3'd0: begin
                    if (mem_req) begin
                        wait_cnt <= 3'(rng % 32'd6) + 3'd1;
                        phase    <= 3'd1;
                    end
                end
                3'd1: begin
                    if (wait_cnt == 3'd1) begin
                        mem_addr_ok <= 1'b1;
                        phase       <= 3'd2;
                    end else begin
                        wait_cnt <= wait_cnt - 3'd1;
                    end
                end
                3'd2: begin
                    // handshake completes on this edge
                    line_base <= {mem_addr[11:4], 4'b0000};
                    last_addr <= mem_addr;
                    last_strb <= mem_wstrb;
                    if (mem_write) begin
                        write_count <= write_count + 1;
                        for (int b = 0; b < 4; b++) begin
                            if (mem_wstrb[b]) begin
                                store[{mem_addr[11:2], 2'(b)}] <= mem_wdata[8 * b +: 8];
                            end
                        end
                    end else begin
                        read_count <= read_count + 1;
                    end
                    wait_cnt <= 3'(rng % 32'd6) + 3'd1;
                    phase    <= 3'd3;
                end
                3'd3: begin
                    if (wait_cnt == 3'd1) begin
                        mem_data_ok <= 1'b1;
                        for (int b = 0; b < 16; b++) begin
                            mem_rdata[8 * b +: 8] <= store[line_base + 12'(b)];
                        end
                        phase <= 3'd4;
                    end else begin
                        wait_cnt <= wait_cnt - 3'd1;
                    end
                end
                default: begin
                    phase <= 3'd0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tb_dcache.sv ====
// data cache testbench
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int NUM_READS    = 40;
    localparam int NUM_WRITES   = 20;
    localparam int NUM_REQ      = NUM_READS + 2 + 2 * NUM_WRITES + 10;
    localparam int WORST_CYCLES = 20;

    logic           clk;
    logic           reset;
    logic           req_valid;
    logic           req_write;
    logic [31:0]    req_addr;
    logic [31:0]    req_wdata;
    logic [3:0]     req_wstrb;
    logic           req_ready;
    logic           resp_valid;
    logic [31:0]    resp_rdata;
    logic           mem_req;
    logic           mem_write;
    logic [31:0]    mem_addr;
    logic [31:0]    mem_wdata;
    logic [3:0]     mem_wstrb;
    logic           mem_addr_ok;
    logic           mem_data_ok;
    logic [LINE_BITS-1:0] mem_rdata;
    int             read_count;
    int             write_count;
    logic [31:0]    last_addr;
    logic [3:0]     last_strb;

    logic [7:0]     shadow [4096];
    logic [31:0]    rng;
    logic [31:0]    exp_q [$];
    logic           is_read_q [$];
    int             last_lat;
    logic [31:0]    wr_addrs [NUM_WRITES];

    dcache_top i_dcache_top (.*);

    tb_mem_model i_tb_mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
    endfunction

    // expected word from the shadow memory after any write merge
    function automatic logic [31:0] ref_word(input logic write, input logic [31:0] addr,
                                             input logic [31:0] wdata, input logic [3:0] strb);
        logic [31:0] word;
        for (int b = 0; b < 4; b++) begin
            if (write && strb[b]) begin
                shadow[{addr[11:2], 2'(b)}] = wdata[8 * b +: 8];
            end
            word[8 * b +: 8] = shadow[{addr[11:2], 2'(b)}];
        end
        return word;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("error %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else
            stop_on_error($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    // drive one request and wait for its response
    task automatic access(input logic write, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb);
        exp_q.push_back(ref_word(write, addr, wdata, strb));
        is_read_q.push_back(!write);
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= write;
        req_addr  <= addr;
        req_wdata <= wdata;
        req_wstrb <= strb;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        last_lat = 0;
        do begin
            @(negedge clk);
            last_lat++;
        end while (!resp_valid);
    endtask

    ////////////////////////////////////////////////////////////
    // response comparison
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin : compare_resp
        logic [31:0] exp_word;
        logic        is_read;
        if (!reset && resp_valid) begin
            assert (exp_q.size() > 0) else
                stop_on_error("response arrived with no request outstanding");
            exp_word = exp_q.pop_front();
            is_read  = is_read_q.pop_front();
            if (is_read) begin
                check_equal(resp_rdata, exp_word, "read data");
            end
        end
    end

    // watchdog
    initial begin
        repeat (NUM_REQ * WORST_CYCLES + 4) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles",
                 NUM_REQ * WORST_CYCLES + 4);
        $display("TESTS FAILED");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] addr;
        logic [3:0]  strb;
        int          rc;
        int          wc;
        rng       = 32'd8137;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = fill_byte(12'(i));
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // random reads over tags 0 to 7
        for (int i = 0; i < NUM_READS; i++) begin
            r    = next_rand();
            addr = {21'b0, r[10:2], 2'b00};
            rc   = read_count;
            access(1'b0, addr, '0, '0);
            // refills fetch the whole line from its first byte
            if (read_count != rc) begin
                check_equal(last_addr, {addr[31:4], 4'b0000}, "refill address at memory");
            end
        end

        // second word of a line just read hits
        access(1'b0, 32'h0000_03a4, '0, '0);
        rc = read_count;
        access(1'b0, 32'h0000_03a8, '0, '0);
        check_equal(read_count, rc, "memory reads after hit");
        check_equal(last_lat, 1, "hit latency");

        // partial writes and their read back
        for (int i = 0; i < NUM_WRITES; i++) begin
            r    = next_rand();
            addr = {21'b0, r[10:2], 2'b00};
            strb = 4'(next_rand() % 32'd16);
            if (strb == 4'b0000) begin
                strb = 4'b0001;
            end
            wr_addrs[i] = addr;
            wc = write_count;
            access(1'b1, addr, next_rand(), strb);
            check_equal(write_count, wc + 1, "memory writes");
            check_equal(last_addr, addr, "write address at memory");
            check_equal({28'b0, last_strb}, {28'b0, strb}, "write strobes at memory");
        end
        for (int i = 0; i < NUM_WRITES; i++) begin
            access(1'b0, wr_addrs[i], '0, '0);
        end

        // write hit updates the cached line
        access(1'b0, 32'h0000_0840, '0, '0);
        rc = read_count;
        access(1'b1, 32'h0000_0840, 32'hcafe_f00d, 4'b0110);
        access(1'b0, 32'h0000_0840, '0, '0);
        check_equal(read_count, rc, "memory reads after write hit");

        // no write-allocate
        rc = read_count;
        access(1'b1, 32'h0000_0960, 32'h1234_5678, 4'b1111);
        check_equal(read_count, rc, "memory reads after write miss");
        access(1'b0, 32'h0000_0960, '0, '0);
        check_equal(read_count, rc + 1, "memory reads after read of unallocated line");

        // lru in set 5 with lines A, B, C
        access(1'b0, 32'h0000_0a50, '0, '0);
        access(1'b0, 32'h0000_0b50, '0, '0);
        access(1'b0, 32'h0000_0c50, '0, '0);
        rc = read_count;
        access(1'b0, 32'h0000_0b50, '0, '0);
        check_equal(read_count, rc, "memory reads for recently used line");
        access(1'b0, 32'h0000_0a50, '0, '0);
        check_equal(read_count, rc + 1, "memory reads for evicted line");

        repeat (2) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
